// ==== flist.f ====
src/SocPkg.sv
src/DBusDecoder.sv
src/DataRam.sv
src/SevenSegGpio.sv
src/BusTimer.sv
src/PeriphSubsystem.sv
bench/PeriphChecker.sv
bench/TbPeriph.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= TbPeriph
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

# Pass only when the log holds the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -o $(TOP) -f $(FLIST)
	./$(BUILD_DIR)/$(TOP) 2>&1 | tee $(LOG)
	grep -q -F -x '** PASS **' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bench/TbPeriph.sv ====
`timescale 1ns/1ps

module TbPeriph import SocPkg::*; ();

    typedef enum logic [1:0] {
        OpWrite,
        OpRead,
        OpIdle
    } tOp;

    // One bus step; for OpIdle the write data holds the number of quiet cycles
    typedef struct packed {
        tOp         Op;
        tWordAddr   Addr;
        tByteEn     ByteEn;
        tWord       WrData;
        tWord       ExpData;
        logic [3:0] ExpWait;
        logic       Check;
    } tEntry;

    localparam tWordAddr RamBase      = {AddrTopPeriph, AddrPeriphRam, 20'd0};
    localparam tWordAddr GpioDigits   = {AddrTopPeriph, AddrPeriphSmall, AddrSmallGpio,
                                         GpioRegDigits};
    localparam tWordAddr GpioEnable   = {AddrTopPeriph, AddrPeriphSmall, AddrSmallGpio,
                                         GpioRegEnable};
    localparam tWordAddr TimerCount   = {AddrTopPeriph, AddrPeriphSmall, AddrSmallTimer,
                                         TimerRegCount};
    localparam tWordAddr TimerCompare = {AddrTopPeriph, AddrPeriphSmall, AddrSmallTimer,
                                         TimerRegCompare};
    localparam tWordAddr TimerControl = {AddrTopPeriph, AddrPeriphSmall, AddrSmallTimer,
                                         TimerRegControl};

    logic       w_SysClk;
    logic       r_Rst;
    tWordAddr   r_Address;
    tByteEn     r_ByteEn;
    logic       r_Read;
    logic       r_Write;
    tWord       r_WriteData;
    tWord       w_ReadData;
    logic       w_WaitRequest;
    logic [2:0] w_7SegEn;
    logic [6:0] w_7SegLed;
    tWord       r_ExpData;
    logic [3:0] r_ExpWait;
    logic       r_Check;
    int         w_DataErrors;
    int         w_WaitErrors;
    int         w_DisplayErrors;
    int         w_LitCycles;
    int         r_BenchErrors;
    int         r_Cycles;
    int         r_CycleLimit;
    logic       r_TableReady;
    integer     r_Seed;
    tEntry      r_Table[$];

    PeriphSubsystem dut0 (
        .w_SysClk           (w_SysClk),
        .i_rst              (r_Rst),
        .i_DBus_Address     (r_Address),
        .i_DBus_ByteEn      (r_ByteEn),
        .i_DBus_Read        (r_Read),
        .i_DBus_Write       (r_Write),
        .i_DBus_WriteData   (r_WriteData),
        .o_DBus_ReadData    (w_ReadData),
        .o_DBus_WaitRequest (w_WaitRequest),
        .o_7Seg_En          (w_7SegEn),
        .o_7Seg_Led         (w_7SegLed)
    );

    PeriphChecker checker0 (
        .w_SysClk           (w_SysClk),
        .i_rst              (r_Rst),
        .i_DBus_Address     (r_Address),
        .i_DBus_ByteEn      (r_ByteEn),
        .i_DBus_Read        (r_Read),
        .i_DBus_Write       (r_Write),
        .i_DBus_WriteData   (r_WriteData),
        .i_DBus_ReadData    (w_ReadData),
        .i_DBus_WaitRequest (w_WaitRequest),
        .i_7Seg_En          (w_7SegEn),
        .i_7Seg_Led         (w_7SegLed),
        .i_ExpData          (r_ExpData),
        .i_ExpWait          (r_ExpWait),
        .i_Check            (r_Check),
        .o_DataErrors       (w_DataErrors),
        .o_WaitErrors       (w_WaitErrors),
        .o_DisplayErrors    (w_DisplayErrors),
        .o_LitCycles        (w_LitCycles)
    );

    initial begin
        w_SysClk = 1'b0;
        forever #5 w_SysClk = ~w_SysClk;
    end

    function automatic tWordAddr RamWord(int i_Index);
        return RamBase | tWordAddr'(i_Index);
    endfunction

    // Byte lanes with their enable set come from the new word
    function automatic tWord MergeLanes(tWord i_Old, tWord i_New, tByteEn i_Lanes);
        tWord w_Keep;
        w_Keep = {{8{i_Lanes[3]}}, {8{i_Lanes[2]}}, {8{i_Lanes[1]}}, {8{i_Lanes[0]}}};
        return (i_Old & ~w_Keep) | (i_New & w_Keep);
    endfunction

    task automatic AddEntry(tOp i_Op, tWordAddr i_Addr, tByteEn i_ByteEn, tWord i_WrData,
                            tWord i_ExpData, logic [3:0] i_ExpWait, logic i_Check);
        tEntry w_Entry;
        w_Entry.Op      = i_Op;
        w_Entry.Addr    = i_Addr;
        w_Entry.ByteEn  = i_ByteEn;
        w_Entry.WrData  = i_WrData;
        w_Entry.ExpData = i_ExpData;
        w_Entry.ExpWait = i_ExpWait;
        w_Entry.Check   = i_Check;
        r_Table.push_back(w_Entry);
    endtask

    task automatic AddWrite(tWordAddr i_Addr, tByteEn i_ByteEn, tWord i_Data);
        AddEntry(OpWrite, i_Addr, i_ByteEn, i_Data, '0, 4'd0, 1'b0);
    endtask

    task automatic AddRead(tWordAddr i_Addr, tWord i_Exp, logic [3:0] i_Wait, logic i_Check);
        AddEntry(OpRead, i_Addr, 4'hF, '0, i_Exp, i_Wait, i_Check);
    endtask

    task automatic AddIdle(int i_Cycles);
        AddEntry(OpIdle, '0, 4'h0, tWord'(i_Cycles), '0, 4'd0, 1'b0);
    endtask

    task automatic BuildTable();
        tWord   w_Init [4];
        tWord   w_Patch [4];
        tWord   w_Final [4];
        tByteEn w_Lanes [4];
        tWord   w_Far;
        w_Lanes = '{4'b1000, 4'b0011, 4'b1100, 4'b0101};
        for (int i = 0; i < 4; i++) begin
            w_Init[i]  = $random(r_Seed);
            w_Patch[i] = $random(r_Seed);
            w_Final[i] = MergeLanes(w_Init[i], w_Patch[i], w_Lanes[i]);
        end
        w_Far = $random(r_Seed);

        // RAM: full words, partial overwrites, then read back
        for (int i = 0; i < 4; i++) AddWrite(RamWord(i), 4'hF, w_Init[i]);
        for (int i = 0; i < 4; i++) AddWrite(RamWord(i), w_Lanes[i], w_Patch[i]);
        for (int i = 0; i < 4; i++) AddRead(RamWord(i), w_Final[i], 4'd1, 1'b1);
        AddRead(RamWord(RamDepth + 2), w_Final[2], 4'd1, 1'b1);
        AddWrite(RamWord(2 * RamDepth + 5), 4'hF, w_Far);
        AddRead(RamWord(5), w_Far, 4'd1, 1'b1);

        // GPIO registers; the second lane write only touches digit 2
        AddWrite(GpioDigits, 4'hF, 32'h0000_0A7C);
        AddRead(GpioDigits, 32'h0000_0A7C, 4'd0, 1'b1);
        AddWrite(GpioEnable, 4'hF, 32'h0000_0005);
        AddRead(GpioEnable, 32'h0000_0005, 4'd0, 1'b1);
        AddIdle(12);
        AddWrite(GpioDigits, 4'b0010, 32'h0000_0300);
        AddRead(GpioDigits, 32'h0000_037C, 4'd0, 1'b1);
        AddWrite(GpioEnable, 4'hF, 32'h0000_0007);

        // Timer
        AddWrite(TimerCount, 4'hF, 32'h0000_0123);
        AddIdle(3);
        AddRead(TimerCount, 32'h0000_0123, 4'd0, 1'b1);
        AddWrite(TimerCompare, 4'hF, 32'd5);
        AddRead(TimerCompare, 32'd5, 4'd0, 1'b1);
        AddWrite(TimerCount, 4'hF, 32'd0);
        AddWrite(TimerControl, 4'hF, 32'h1);
        AddIdle(20);
        // Twenty counts from zero, wrapping after the compare value
        AddRead(TimerCount, tWord'(20 % (5 + 1)), 4'd0, 1'b1);
        AddRead(TimerControl, 32'h3, 4'd0, 1'b1);
        AddWrite(TimerControl, 4'hF, 32'h0);
        AddRead(TimerControl, 32'h2, 4'd0, 1'b1);
        AddWrite(TimerControl, 4'hF, 32'h2);
        AddRead(TimerControl, 32'h0, 4'd0, 1'b1);

        // Unmapped space
        AddRead(30'h0000_0040, '0, 4'd0, 1'b1);
        AddRead({AddrTopPeriph, AddrPeriphSmall, 10'd5, 10'd0}, '0, 4'd0, 1'b1);
        AddWrite(30'h2000_0003, 4'hF, 32'h5A5A_A5A5);
        AddWrite({AddrTopPeriph, 8'd1, 20'd3}, 4'hF, 32'h5A5A_A5A5);
        AddRead(RamWord(3), w_Final[3], 4'd1, 1'b1);
    endtask

    task automatic ApplyEntry(tEntry i_Entry);
        logic w_Stalled;
        @(posedge w_SysClk);
        r_Address   <= i_Entry.Addr;
        r_ByteEn    <= i_Entry.ByteEn;
        r_Read      <= (i_Entry.Op == OpRead);
        r_Write     <= (i_Entry.Op == OpWrite);
        r_WriteData <= i_Entry.WrData;
        r_ExpData   <= i_Entry.ExpData;
        r_ExpWait   <= i_Entry.ExpWait;
        r_Check     <= i_Entry.Check;
        if (i_Entry.Op == OpIdle) begin
            repeat (i_Entry.WrData - 1) @(posedge w_SysClk);
        end else begin
            // Hold until the slave stops stalling
            do begin
                @(negedge w_SysClk);
                w_Stalled = w_WaitRequest;
            end while (w_Stalled);
        end
    endtask

    task automatic PrintCounts();
        $display("Errors: data %0d, wait %0d, display %0d, bench %0d",
                 w_DataErrors, w_WaitErrors, w_DisplayErrors, r_BenchErrors);
    endtask

    initial begin
        r_Rst         = 1'b1;
        r_Address     = '0;
        r_ByteEn      = '0;
        r_Read        = 1'b0;
        r_Write       = 1'b0;
        r_WriteData   = '0;
        r_ExpData     = '0;
        r_ExpWait     = '0;
        r_Check       = 1'b0;
        r_BenchErrors = 0;
        r_TableReady  = 1'b0;
        r_Seed        = 32'haf4a98dc;
        BuildTable();
        r_CycleLimit  = 8 * r_Table.size() + 100;
        r_TableReady  = 1'b1;

        repeat (3) @(posedge w_SysClk);
        r_Rst <= 1'b0;

        foreach (r_Table[i]) ApplyEntry(r_Table[i]);
        @(posedge w_SysClk);
        r_Read  <= 1'b0;
        r_Write <= 1'b0;
        r_Check <= 1'b0;
        repeat (4) @(posedge w_SysClk);

        if (w_LitCycles == 0) begin
            $display("The display was never lit, so no segment pattern was checked");
            r_BenchErrors++;
        end
        PrintCounts();
        if (w_DataErrors + w_WaitErrors + w_DisplayErrors + r_BenchErrors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // Run limit scales with the table length
    initial begin
        r_Cycles = 0;
        wait (r_TableReady);
        while (r_Cycles < r_CycleLimit) begin
            @(posedge w_SysClk);
            r_Cycles++;
        end
        $display("Timeout: the run did not finish within %0d clock cycles", r_CycleLimit);
        PrintCounts();
        $display("** FAIL **");
        $finish;
    end

endmodule

// ==== bench/PeriphChecker.sv ====
`timescale 1ns/1ps

module PeriphChecker import SocPkg::*; (
    input  logic       w_SysClk,
    input  logic       i_rst,

    // Bus as seen at the DUT ports
    input  tWordAddr   i_DBus_Address,
    input  tByteEn     i_DBus_ByteEn,
    input  logic       i_DBus_Read,
    input  logic       i_DBus_Write,
    input  tWord       i_DBus_WriteData,
    input  tWord       i_DBus_ReadData,
    input  logic       i_DBus_WaitRequest,
    input  logic [2:0] i_7Seg_En,
    input  logic [6:0] i_7Seg_Led,

    // Expected response of the transfer on the bus
    input  tWord       i_ExpData,
    input  logic [3:0] i_ExpWait,
    input  logic       i_Check,

    output int         o_DataErrors,
    output int         o_WaitErrors,
    output int         o_DisplayErrors,
    output int         o_LitCycles
);

    localparam tWordAddr GpioDigitsAddr = {AddrTopPeriph, AddrPeriphSmall, AddrSmallGpio,
                                           GpioRegDigits};
    localparam tWordAddr GpioEnableAddr = {AddrTopPeriph, AddrPeriphSmall, AddrSmallGpio,
                                           GpioRegEnable};

    // Per segment, which of the 16 hex digits light it (g first, a last)
    localparam logic [6:0][15:0] SegUse = {16'hEF7C, 16'hDF71, 16'hFD45, 16'h7B6D,
                                           16'h2FFB, 16'h279F, 16'hD7ED};

    logic [11:0] r_Digits;
    logic [2:0]  r_Mask;
    logic [3:0]  r_WaitCnt;
    logic        r_AfterRst;
    logic        w_Done;

    function automatic logic [6:0] SegFromUse(logic [3:0] i_Hex);
        logic [6:0] w_Seg;
        for (int s = 0; s < 7; s++) begin
            w_Seg[s] = SegUse[s][i_Hex];
        end
        return w_Seg;
    endfunction

    assign w_Done = (i_DBus_Read || i_DBus_Write) && !i_DBus_WaitRequest;

    // Stall cycles seen so far in the current transfer
    always @(posedge w_SysClk) begin
        if (i_rst || w_Done) begin
            r_WaitCnt <= '0;
        end else if ((i_DBus_Read || i_DBus_Write) && i_DBus_WaitRequest) begin
            r_WaitCnt <= r_WaitCnt + 4'd1;
        end
    end

    always @(posedge w_SysClk) begin
        if (i_rst) begin
            o_DataErrors <= 0;
            o_WaitErrors <= 0;
        end else if (w_Done) begin
            if (r_WaitCnt != i_ExpWait) begin
                $display("error o_DBus_WaitRequest cycles at 0x%08h: got 0x%0h, expected 0x%0h",
                         i_DBus_Address, r_WaitCnt, i_ExpWait);
                o_WaitErrors <= o_WaitErrors + 1;
            end
            if (i_DBus_Read && i_Check && i_DBus_ReadData !== i_ExpData) begin
                $display("error o_DBus_ReadData at 0x%08h: got 0x%08h, expected 0x%08h",
                         i_DBus_Address, i_DBus_ReadData, i_ExpData);
                o_DataErrors <= o_DataErrors + 1;
            end
        end else if (!i_DBus_Read && !i_DBus_Write && i_DBus_WaitRequest !== 1'b0) begin
            $display("WaitRequest is high while no transfer is on the bus");
            o_WaitErrors <= o_WaitErrors + 1;
        end
    end

    // Shadow of the GPIO registers, updated by completed writes
    always @(posedge w_SysClk) begin
        if (i_rst) begin
            r_Digits <= '0;
            r_Mask   <= '0;
        end else if (i_DBus_Write && w_Done) begin
            if (i_DBus_Address == GpioDigitsAddr) begin
                if (i_DBus_ByteEn[0]) begin
                    r_Digits[7:0] <= i_DBus_WriteData[7:0];
                end
                if (i_DBus_ByteEn[1]) begin
                    r_Digits[11:8] <= i_DBus_WriteData[11:8];
                end
            end else if (i_DBus_Address == GpioEnableAddr && i_DBus_ByteEn[0]) begin
                r_Mask <= i_DBus_WriteData[2:0];
            end
        end
    end

    always @(posedge w_SysClk) begin : CheckDisplay
        int         w_Bad;
        logic [6:0] w_Expect;
        w_Bad = 0;
        if (i_rst) begin
            r_AfterRst      <= 1'b1;
            o_DisplayErrors <= 0;
            o_LitCycles     <= 0;
        end else begin
            r_AfterRst <= 1'b0;
            if (r_AfterRst && i_7Seg_En !== 3'b000) begin
                $display("Display enables are not all off right after reset");
                w_Bad++;
            end
            if (!$onehot0(i_7Seg_En)) begin
                $display("More than one display digit is enabled at once");
                w_Bad++;
            end
            for (int k = 0; k < 3; k++) begin
                if (i_7Seg_En[k]) begin
                    w_Expect = SegFromUse(r_Digits[4*k +: 4]);
                    if (!r_Mask[k]) begin
                        $display("Digit %0d is lit while its enable bit is clear", k);
                        w_Bad++;
                    end
                    if (i_7Seg_Led !== w_Expect) begin
                        $display("error o_7Seg_Led on digit %0d: got 0x%02h, expected 0x%02h",
                                 k, i_7Seg_Led, w_Expect);
                        w_Bad++;
                    end
                end
            end
            if (i_7Seg_En != 3'b000) begin
                o_LitCycles <= o_LitCycles + 1;
            end
            o_DisplayErrors <= o_DisplayErrors + w_Bad;
        end
    end

endmodule

// ==== src/PeriphSubsystem.sv ====
`timescale 1ns/1ps

module PeriphSubsystem import SocPkg::*; (
    input  logic       w_SysClk,
    input  logic       i_rst,

    // Data bus, driven by the single master
    input  tWordAddr   i_DBus_Address,
    input  tByteEn     i_DBus_ByteEn,
    input  logic       i_DBus_Read,
    input  logic       i_DBus_Write,
    input  tWord       i_DBus_WriteData,
    output tWord       o_DBus_ReadData,
    output logic       o_DBus_WaitRequest,

    // Display pins
    output logic [2:0] o_7Seg_En,
    output logic [6:0] o_7Seg_Led
);

    logic      w_RamSel;
    logic      w_GpioSel;
    logic      w_TimerSel;
    tPeriphReg w_PeriphReg;
    tSmallReg  w_SmallReg;
    tWord      w_RamReadData;
    tWord      w_GpioReadData;
    tWord      w_TimerReadData;
    logic      w_RamWait;
    logic      w_GpioWait;
    logic      w_TimerWait;

    DBusDecoder decoder0 (
        .w_SysClk           (w_SysClk),
        .i_rst              (i_rst),
        .i_DBus_Address     (i_DBus_Address),
        .o_RamSel           (w_RamSel),
        .o_GpioSel          (w_GpioSel),
        .o_TimerSel         (w_TimerSel),
        .o_PeriphReg        (w_PeriphReg),
        .o_SmallReg         (w_SmallReg),
        .i_RamReadData      (w_RamReadData),
        .i_GpioReadData     (w_GpioReadData),
        .i_TimerReadData    (w_TimerReadData),
        .i_RamWait          (w_RamWait),
        .i_GpioWait         (w_GpioWait),
        .i_TimerWait        (w_TimerWait),
        .o_DBus_ReadData    (o_DBus_ReadData),
        .o_DBus_WaitRequest (o_DBus_WaitRequest)
    );

    DataRam ram0 (
        .w_SysClk      (w_SysClk),
        .i_rst         (i_rst),
        .i_Sel         (w_RamSel),
        .i_RegAddr     (w_PeriphReg),
        .i_ByteEn      (i_DBus_ByteEn),
        .i_Read        (i_DBus_Read),
        .i_Write       (i_DBus_Write),
        .i_WriteData   (i_DBus_WriteData),
        .o_ReadData    (w_RamReadData),
        .o_WaitRequest (w_RamWait)
    );

    SevenSegGpio gpio0 (
        .w_SysClk      (w_SysClk),
        .i_rst         (i_rst),
        .i_Sel         (w_GpioSel),
        .i_RegAddr     (w_SmallReg),
        .i_ByteEn      (i_DBus_ByteEn),
        .i_Read        (i_DBus_Read),
        .i_Write       (i_DBus_Write),
        .i_WriteData   (i_DBus_WriteData),
        .o_ReadData    (w_GpioReadData),
        .o_WaitRequest (w_GpioWait),
        .o_7Seg_En     (o_7Seg_En),
        .o_7Seg_Led    (o_7Seg_Led)
    );

    BusTimer timer0 (
        .w_SysClk      (w_SysClk),
        .i_rst         (i_rst),
        .i_Sel         (w_TimerSel),
        .i_RegAddr     (w_SmallReg),
        .i_ByteEn      (i_DBus_ByteEn),
        .i_Read        (i_DBus_Read),
        .i_Write       (i_DBus_Write),
        .i_WriteData   (i_DBus_WriteData),
        .o_ReadData    (w_TimerReadData),
        .o_WaitRequest (w_TimerWait)
    );

endmodule

// ==== src/BusTimer.sv ====
`timescale 1ns/1ps

module BusTimer import SocPkg::*; (
    input  logic     w_SysClk,
    input  logic     i_rst,

    input  logic     i_Sel,
    input  tSmallReg i_RegAddr,
    input  tByteEn   i_ByteEn,
    input  logic     i_Read,
    input  logic     i_Write,
    input  tWord     i_WriteData,
    output tWord     o_ReadData,
    output logic     o_WaitRequest
);

    tWord r_Count;
    tWord r_Compare;
    logic r_Enable;
    logic r_Match;
    logic w_CountWrite;
    logic w_CompareWrite;
    logic w_ControlWrite;

    assign w_CountWrite   = i_Sel && i_Write && (i_RegAddr == TimerRegCount);
    assign w_CompareWrite = i_Sel && i_Write && (i_RegAddr == TimerRegCompare);
    assign w_ControlWrite = i_Sel && i_Write && (i_RegAddr == TimerRegControl) && i_ByteEn[0];

    always_ff @(posedge w_SysClk) begin
        if (i_rst) begin
            r_Count   <= '0;
            r_Compare <= '0;
            r_Enable  <= 1'b0;
            r_Match   <= 1'b0;
        end else begin
            if (w_CompareWrite) r_Compare <= MergeBytes(r_Compare, i_WriteData, i_ByteEn);
            if (w_ControlWrite) begin
                r_Enable <= i_WriteData[0];
                // Write one to clear
                if (i_WriteData[1]) r_Match <= 1'b0;
            end
            if (w_CountWrite) begin
                r_Count <= MergeBytes(r_Count, i_WriteData, i_ByteEn);
            end else if (r_Enable) begin
                if (r_Count == r_Compare) begin
                    r_Count <= '0;
                    // A new match wins over a clear in the same cycle
                    r_Match <= 1'b1;
                end else begin
                    r_Count <= r_Count + 1'b1;
                end
            end
        end
    end

    always_comb begin
        o_ReadData = '0;
        if (i_Sel && i_Read) begin
            case (i_RegAddr)
                TimerRegCount:   o_ReadData = r_Count;
                TimerRegCompare: o_ReadData = r_Compare;
                TimerRegControl: o_ReadData = {30'd0, r_Match, r_Enable};
                default:         o_ReadData = '0;
            endcase
        end
    end

    assign o_WaitRequest = 1'b0;

    // Once below compare, counting keeps it there until software moves either value
    a_CountBounded: assert property (
        @(posedge w_SysClk) disable iff (i_rst)
        (r_Enable && $past(r_Enable) && $past(r_Count <= r_Compare)
            && !$past(w_CountWrite) && !$past(w_CompareWrite))
        |-> (r_Count <= r_Compare)
    ) else $error("BusTimer: count 0x%08h passed compare 0x%08h", r_Count, r_Compare);

endmodule

// ==== src/SevenSegGpio.sv ====
`timescale 1ns/1ps

module SevenSegGpio import SocPkg::*; (
    input  logic       w_SysClk,
    input  logic       i_rst,

    input  logic       i_Sel,
    input  tSmallReg   i_RegAddr,
    input  tByteEn     i_ByteEn,
    input  logic       i_Read,
    input  logic       i_Write,
    input  tWord       i_WriteData,
    output tWord       o_ReadData,
    output logic       o_WaitRequest,

    output logic [2:0] o_7Seg_En,
    output logic [6:0] o_7Seg_Led
);

    logic [11:0]            r_Digits;
    logic [2:0]             r_Enable;
    logic [ScanCntBits-1:0] r_ScanCnt;
    logic [1:0]             r_DigitIdx;
    logic [3:0]             w_Nibble;

    // Segment pattern, g down to a, lit when high
    function automatic logic [6:0] HexToSeg(logic [3:0] i_Hex);
        case (i_Hex)
            4'h0: return 7'h3F;
            4'h1: return 7'h06;
            4'h2: return 7'h5B;
            4'h3: return 7'h4F;
            4'h4: return 7'h66;
            4'h5: return 7'h6D;
            4'h6: return 7'h7D;
            4'h7: return 7'h07;
            4'h8: return 7'h7F;
            4'h9: return 7'h6F;
            4'hA: return 7'h77;
            4'hB: return 7'h7C;
            4'hC: return 7'h39;
            4'hD: return 7'h5E;
            4'hE: return 7'h79;
            default: return 7'h71;
        endcase
    endfunction

    // Register writes, byte lane by byte lane
    always_ff @(posedge w_SysClk) begin
        if (i_rst) begin
            r_Digits <= '0;
            r_Enable <= '0;
        end else if (i_Sel && i_Write) begin
            if (i_RegAddr == GpioRegDigits) begin
                if (i_ByteEn[0]) r_Digits[7:0]  <= i_WriteData[7:0];
                if (i_ByteEn[1]) r_Digits[11:8] <= i_WriteData[11:8];
            end else if (i_RegAddr == GpioRegEnable && i_ByteEn[0]) begin
                r_Enable <= i_WriteData[2:0];
            end
        end
    end

    // Digit scan 0, 1, 2, each held for ScanDiv cycles
    always_ff @(posedge w_SysClk) begin
        if (i_rst) begin
            r_ScanCnt  <= '0;
            r_DigitIdx <= '0;
        end else if (r_ScanCnt == ScanCntBits'(ScanDiv - 1)) begin
            r_ScanCnt  <= '0;
            r_DigitIdx <= (r_DigitIdx == 2'd2) ? 2'd0 : r_DigitIdx + 2'd1;
        end else begin
            r_ScanCnt <= r_ScanCnt + 1'b1;
        end
    end

    assign w_Nibble   = r_Digits[4*r_DigitIdx +: 4];
    assign o_7Seg_En  = (3'b001 << r_DigitIdx) & r_Enable;
    assign o_7Seg_Led = HexToSeg(w_Nibble);

    always_comb begin
        o_ReadData = '0;
        if (i_Sel && i_Read) begin
            if (i_RegAddr == GpioRegDigits) o_ReadData = {20'd0, r_Digits};
            if (i_RegAddr == GpioRegEnable) o_ReadData = {29'd0, r_Enable};
        end
    end

    // Register slave, never stalls
    assign o_WaitRequest = 1'b0;

endmodule

// ==== src/DataRam.sv ====
`timescale 1ns/1ps

module DataRam import SocPkg::*; (
    input  logic      w_SysClk,
    input  logic      i_rst,

    input  logic      i_Sel,
    input  tPeriphReg i_RegAddr,
    input  tByteEn    i_ByteEn,
    input  logic      i_Read,
    input  logic      i_Write,
    input  tWord      i_WriteData,
    output tWord      o_ReadData,
    output logic      o_WaitRequest
);

    tWord                   r_Mem [RamDepth];
    tWord                   r_ReadWord;
    tRamState               r_State;
    logic [RamAddrBits-1:0] w_Index;
    logic                   w_ReadStart;

    // Upper register bits are ignored, so the array repeats
    assign w_Index = i_RegAddr[RamAddrBits-1:0];

    // First cycle of a read strobe
    assign w_ReadStart = i_Sel && i_Read && (r_State == RamIdle);

    always_ff @(posedge w_SysClk) begin
        if (i_rst) begin
            r_State <= RamIdle;
        end else begin
            case (r_State)
                RamIdle: begin
                    if (w_ReadStart) begin
                        r_State <= RamReadWait;
                    end
                end
                RamReadWait: begin
                    r_State <= RamIdle;
                end
                default: r_State <= RamIdle;
            endcase
        end
    end

    always_ff @(posedge w_SysClk) begin
        if (w_ReadStart) begin
            r_ReadWord <= r_Mem[w_Index];
        end
        if (i_Sel && i_Write) begin
            r_Mem[w_Index] <= MergeBytes(r_Mem[w_Index], i_WriteData, i_ByteEn);
        end
    end

    // Stall one cycle, then hand back the registered word
    assign o_WaitRequest = w_ReadStart;
    assign o_ReadData    = (i_Sel && r_State == RamReadWait) ? r_ReadWord : '0;

    a_NoReadWrite: assert property (
        @(posedge w_SysClk) disable iff (i_rst)
        i_Sel |-> !(i_Read && i_Write)
    ) else $error("DataRam: read and write strobes high together");

endmodule

// ==== src/DBusDecoder.sv ====
`timescale 1ns/1ps

module DBusDecoder import SocPkg::*; (
    input  logic      w_SysClk,
    input  logic      i_rst,

    input  tWordAddr  i_DBus_Address,

    // Slave selects and register fields
    output logic      o_RamSel,
    output logic      o_GpioSel,
    output logic      o_TimerSel,
    output tPeriphReg o_PeriphReg,
    output tSmallReg  o_SmallReg,

    // Slave responses
    input  tWord      i_RamReadData,
    input  tWord      i_GpioReadData,
    input  tWord      i_TimerReadData,
    input  logic      i_RamWait,
    input  logic      i_GpioWait,
    input  logic      i_TimerWait,

    output tWord      o_DBus_ReadData,
    output logic      o_DBus_WaitRequest
);

    logic [1:0] w_TopField;
    logic [7:0] w_PeriphField;
    tSmallReg   w_SmallField;
    logic       w_InPeriph;
    logic       w_InSmall;

    // Word address layout: top | periph select | periph register
    assign w_TopField    = i_DBus_Address[29:28];
    assign w_PeriphField = i_DBus_Address[27:20];
    assign o_PeriphReg   = i_DBus_Address[19:0];

    // Inside the small block: small select | small register
    assign w_SmallField  = o_PeriphReg[19:10];
    assign o_SmallReg    = o_PeriphReg[9:0];

    assign w_InPeriph = (w_TopField == AddrTopPeriph);
    assign w_InSmall  = w_InPeriph && (w_PeriphField == AddrPeriphSmall);

    assign o_RamSel   = w_InPeriph && (w_PeriphField == AddrPeriphRam);
    assign o_GpioSel  = w_InSmall && (w_SmallField == AddrSmallGpio);
    assign o_TimerSel = w_InSmall && (w_SmallField == AddrSmallTimer);

    // Unselected slaves return zeros, so a plain OR is enough
    // Unmapped addresses fall out as zero data with no wait
    assign o_DBus_ReadData    = i_RamReadData | i_GpioReadData | i_TimerReadData;
    assign o_DBus_WaitRequest = i_RamWait | i_GpioWait | i_TimerWait;

    // Address map regions must not overlap
    a_OneSelect: assert property (
        @(posedge w_SysClk) disable iff (i_rst)
        $onehot0({o_RamSel, o_GpioSel, o_TimerSel})
    ) else $error("DBusDecoder: more than one slave selected");

endmodule

// ==== src/SocPkg.sv ====
package SocPkg;

    // Bus widths
    typedef logic [31:0] tWord;
    typedef logic [29:0] tWordAddr;
    typedef logic [3:0]  tByteEn;

    // Register fields left below each select level
    typedef logic [19:0] tPeriphReg;
    typedef logic [9:0]  tSmallReg;

    // Address map, from the top of the word address down
    localparam logic [1:0] AddrTopPeriph   = 2'd3;
    localparam logic [7:0] AddrPeriphRam   = 8'd0;
    localparam logic [7:0] AddrPeriphSmall = 8'd255;
    localparam tSmallReg   AddrSmallGpio   = 10'd2;
    localparam tSmallReg   AddrSmallTimer  = 10'd9;

    // RAM geometry
    localparam int RamDepth    = 512;
    localparam int RamAddrBits = $clog2(RamDepth);

    // Cycles each display digit stays lit
    localparam int ScanDiv     = 4;
    localparam int ScanCntBits = $clog2(ScanDiv);

    // GPIO register offsets
    localparam tSmallReg GpioRegDigits = 10'd0;
    localparam tSmallReg GpioRegEnable = 10'd1;

    // Timer register offsets
    localparam tSmallReg TimerRegCount   = 10'd0;
    localparam tSmallReg TimerRegCompare = 10'd1;
    localparam tSmallReg TimerRegControl = 10'd2;

    typedef enum logic {
        RamIdle,
        RamReadWait
    } tRamState;

    // Replace only the byte lanes that are enabled
    function automatic tWord MergeBytes(tWord i_Old, tWord i_New, tByteEn i_ByteEn);
        tWord w_Result;
        w_Result = i_Old;
        for (int b = 0; b < 4; b++) begin
            if (i_ByteEn[b]) begin
                w_Result[8*b +: 8] = i_New[8*b +: 8];
            end
        end
        return w_Result;
    endfunction

endpackage
